//--- fx_pkg.sv
`default_nettype none

package fx_pkg;

	// effect select, as driven on fx.sel
	typedef enum logic [1:0] {
		FX_NONE     = 2'd0,
		FX_PORTA    = 2'd1,
		FX_VIBRATO  = 2'd2,
		FX_RESERVED = 2'd3	// acts like FX_NONE
	} fx_sel_e;

	// effect control bundle from the sequencer
	typedef struct packed {
		fx_sel_e    sel;
		logic [1:0] opt_a;	// porta speed / vibrato speed
		logic [1:0] opt_b;	// vibrato depth
	} fx_ctrl_t;

	// frequency offset into the oscillator
	// dir 1 shortens the half period (pitch up), dir 0 lengthens it
	typedef struct packed {
		logic       dir;
		logic [2:0] mul;	// multiples of H >> 5
	} freq_offset_t;

endpackage

`default_nettype wire

//--- fx_portamento.sv
`timescale 1ns/1ns
`default_nettype none

module fx_portamento (
	input  wire logic            clk50mhz,
	input  wire logic            rst_n,
	input  wire note_pkg::note_t note_in,
	input  wire logic            note_clk,	// one cycle tick
	input  wire logic [1:0]      speed_sel,	// ticks per step minus one
	input  wire logic            en,
	output note_pkg::note_t      porta_note
);

	import note_pkg::*;

	logic [1:0] tick_cnt;	// ticks since last step
	logic       at_target;
	logic       going_up;

	assign at_target = (porta_note == note_in);
	assign going_up  = (porta_note < note_in);

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			porta_note <= '0;
			tick_cnt   <= '0;
		end
		else if (!en)
		begin
			// follow the played note, next slide starts from here
			porta_note <= note_in;
			tick_cnt   <= '0;
		end
		else if (note_clk)
		begin
			if (at_target)
			begin
				tick_cnt <= '0;	// parked, restart pacing on next change
			end
			else if (tick_cnt == speed_sel)
			begin
				tick_cnt <= '0;
				// one semitone toward the target
				if (going_up)
				begin
					if (porta_note != NOTE_MAX)
					begin
						porta_note <= porta_note + 6'd1;
					end
				end
				else
				begin
					porta_note <= porta_note - 6'd1;
				end
			end
			else
			begin
				tick_cnt <= tick_cnt + 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- fx_vibrato.sv
`timescale 1ns/1ns
`default_nettype none

module fx_vibrato (
	input  wire logic          clk50mhz,
	input  wire logic          rst_n,
	input  wire logic          note_clk,	// one cycle tick
	input  wire logic [1:0]    speed,	// ticks per step minus one
	input  wire logic [1:0]    depth,	// peak = 2 * depth + 1
	input  wire logic          en,
	output fx_pkg::freq_offset_t vib_offset
);

	import fx_pkg::*;

	freq_offset_t offs_q;	// current dir and magnitude
	logic [1:0]   tick_cnt;
	logic         rising;	// climbing toward peak
	logic [2:0]   peak;
	logic         step_now;

	assign peak     = {depth, 1'b1};	// 1, 3, 5, 7
	assign step_now = note_clk && (tick_cnt == speed);

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n || !en)
		begin
			// idle: no offset, next triangle starts rising
			offs_q   <= '0;
			tick_cnt <= '0;
			rising   <= 1'b1;
		end
		else if (note_clk)
		begin
			if (step_now)
			begin
				tick_cnt <= '0;
				if (rising && (offs_q.mul < peak))
				begin
					offs_q.mul <= offs_q.mul + 3'd1;
				end
				else
				begin
					// on the way down, also covers a depth cut mid-triangle
					offs_q.mul <= offs_q.mul - 3'd1;
					rising     <= 1'b0;
					if (offs_q.mul == 3'd1)
					begin
						// back at zero, swap sign for the next triangle
						offs_q.dir <= ~offs_q.dir;
						rising     <= 1'b1;
					end
				end
			end
			else
			begin
				tick_cnt <= tick_cnt + 2'd1;
			end
		end
	end

	assign vib_offset = offs_q;

endmodule

`default_nettype wire

//--- note_pkg.sv
`default_nettype none

package note_pkg;

	typedef logic [5:0] note_t;	// octave * 12 + semitone

	localparam note_t NOTE_MAX = 6'd63;

	// half period in clk50mhz cycles for each semitone of octave 1
	// C1 = 32.703 Hz, rest of the octave in equal temperament
	function automatic logic [19:0] semitone_period(input logic [3:0] semi);
		case (semi)
			4'd0: return 20'd764467;	// C
			4'd1: return 20'd721561;	// C#
			4'd2: return 20'd681063;	// D
			4'd3: return 20'd642838;	// D#
			4'd4: return 20'd606758;	// E
			4'd5: return 20'd572703;	// F
			4'd6: return 20'd540560;	// F#
			4'd7: return 20'd510221;	// G
			4'd8: return 20'd481584;	// G#
			4'd9: return 20'd454555;	// A
			4'd10: return 20'd429043;	// A#
			4'd11: return 20'd404962;	// B
			default: return 20'd764467;	// 12..15 never come out of note_semitone
		endcase
	endfunction

	// octave 0..5 for the full note range
	function automatic logic [2:0] note_octave(input note_t n);
		return 3'(n / 6'd12);
	endfunction

	function automatic logic [3:0] note_semitone(input note_t n);
		return 4'(n % 6'd12);
	endfunction

endpackage

`default_nettype wire

//--- project.f
+incdir+.
note_pkg.sv
fx_pkg.sv
fx_portamento.sv
fx_vibrato.sv
square_osc.sv
sq_channel.sv
tb_sq_channel.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ns --top-module tb_sq_channel \
	-f project.f -o tb_sq_channel \
	&& ./obj_dir/tb_sq_channel | grep -F "*** TEST PASSED ***" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sq_channel.sv
`timescale 1ns/1ns
`default_nettype none

module sq_channel #(
	parameter int PERIOD_SHIFT = 0	// passed to the oscillator
) (
	input  wire logic             clk50mhz,
	input  wire logic             rst_n,
	input  wire note_pkg::note_t  note_in,
	input  wire logic             note_clk,	// note rate tick
	input  wire logic             channel_en,
	input  wire fx_pkg::fx_ctrl_t fx,
	output logic [3:0]            wave_out
);

	import note_pkg::*;
	import fx_pkg::*;

	logic         porta_en;
	logic         vibra_en;
	note_t        porta_note;	// slid note from portamento
	note_t        note_sel;	// note into the oscillator
	freq_offset_t vib_offset;
	freq_offset_t offset_sel;

	// effect decode, one cycle behind fx.sel
	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			porta_en <= 1'b0;
			vibra_en <= 1'b0;
		end
		else
		begin
			case (fx.sel)
				FX_PORTA:
				begin
					porta_en <= 1'b1;
					vibra_en <= 1'b0;
				end
				FX_VIBRATO:
				begin
					porta_en <= 1'b0;
					vibra_en <= 1'b1;
				end
				default:	// FX_NONE and FX_RESERVED
				begin
					porta_en <= 1'b0;
					vibra_en <= 1'b0;
				end
			endcase
		end
	end

	fx_portamento u_porta (
		.clk50mhz   (clk50mhz),
		.rst_n      (rst_n),
		.note_in    (note_in),
		.note_clk   (note_clk),
		.speed_sel  (fx.opt_a),
		.en         (porta_en),
		.porta_note (porta_note)
	);

	fx_vibrato u_vibra (
		.clk50mhz   (clk50mhz),
		.rst_n      (rst_n),
		.note_clk   (note_clk),
		.speed      (fx.opt_a),	// larger is slower
		.depth      (fx.opt_b),
		.en         (vibra_en),
		.vib_offset (vib_offset)
	);

	// vibrato keeps the note and only bends the period
	assign note_sel   = porta_en ? porta_note : note_in;
	assign offset_sel = vibra_en ? vib_offset : '0;

	square_osc #(
		.PERIOD_SHIFT (PERIOD_SHIFT)
	) u_osc (
		.clk50mhz (clk50mhz),
		.rst_n    (rst_n),
		.note     (note_sel),
		.offset   (offset_sel),
		.en       (channel_en),
		.wave_out (wave_out)
	);

endmodule

`default_nettype wire

//--- square_osc.sv
`timescale 1ns/1ns
`default_nettype none

module square_osc #(
	parameter int PERIOD_SHIFT = 0	// extra divide of every half period, 0..10
) (
	input  wire logic                 clk50mhz,
	input  wire logic                 rst_n,
	input  wire note_pkg::note_t      note,
	input  wire fx_pkg::freq_offset_t offset,
	input  wire logic                 en,
	output logic [3:0]                wave_out
);

	import note_pkg::*;

	logic [19:0] base_half;	// H for the note
	logic [19:0] step;	// one offset unit, H >> 5
	logic [19:0] delta;	// mul * step
	logic [19:0] eff_half;	// H corrected by the offset
	logic [19:0] half_q;	// registered reload value
	logic [19:0] cnt;	// cycles left in this level
	logic        phase;	// high or low half of the square

	// table lookup, then octave, then global shift
	always_comb
	begin
		base_half = semitone_period(note_semitone(note));
		base_half = base_half >> note_octave(note);
		base_half = base_half >> PERIOD_SHIFT;
		step      = base_half >> 5;
		delta     = step * {17'd0, offset.mul};	// max 7 * H/32, never wraps
		if (offset.dir)
		begin
			eff_half = base_half - delta;	// pitch up
		end
		else
		begin
			eff_half = base_half + delta;	// pitch down
		end
	end

	// break the divide / table path away from the counter
	always_ff @(posedge clk50mhz)
	begin
		half_q <= eff_half;
	end

	// count down, toggle and reload at zero
	// each level lasts half_q cycles
	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n || !en)
		begin
			cnt   <= '0;	// first enabled cycle toggles high
			phase <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt   <= half_q - 20'd1;	// new note or offset lands here
			phase <= ~phase;
		end
		else
		begin
			cnt <= cnt - 20'd1;
		end
	end

	assign wave_out = (phase && en) ? 4'hF : 4'h0;	// full scale or silent

endmodule

`default_nettype wire

//--- tb_sq_tasks.svh
`ifndef TB_SQ_TASKS_SVH
`define TB_SQ_TASKS_SVH

// returns on the first negedge of the next level
task automatic wait_toggle();
	logic [3:0] cur;
	int         guard;
	@(negedge clk50mhz);
	cur   = wave_out;
	guard = 0;
	while (wave_out == cur)
	begin
		@(negedge clk50mhz);
		guard++;
		if (guard > RUN_LIMIT)
			report_timeout("wave_out never changed level");
	end
endtask

// cycles in the run that started at this negedge
// leaves us on the first negedge of the next run
task automatic measure_run(output int len);
	logic [3:0] lvl;
	lvl = wave_out;
	len = 0;
	while (wave_out == lvl)
	begin
		len++;
		@(negedge clk50mhz);
		if (len > RUN_LIMIT)
			report_timeout("wave_out stuck at one level");
	end
endtask

task automatic check_run(input int exp, input string what);
	int len;
	measure_run(len);
	assert (len == exp)
		else report_error($sformatf("%s run %0d, expected %0d", what, len, exp));
endtask

// FX_NONE and FX_RESERVED give the bare note period
task automatic test_plain();
	int n;
	int oa;
	int ob;
	int len;
	for (int k = 0; k < 6; k++)
	begin
		take_bits(6, n);
		take_bits(2, oa);	// options should not matter here
		take_bits(2, ob);
		apply_inputs(n, (k < 3) ? FX_NONE : FX_RESERVED, oa, ob, 1'b1);
		wait_toggle();
		measure_run(len);	// may still carry the old period
		check_run(half_of(n), "plain");
		check_run(half_of(n), "plain");
	end
endtask

task automatic test_enable();
	int n;
	int h;
	int len;
	take_bits(6, n);
	h = half_of(n);
	apply_inputs(n, FX_NONE, 0, 0, 1'b1);
	wait_toggle();
	measure_run(len);
	apply_inputs(n, FX_NONE, 0, 0, 1'b0);
	for (int i = 0; i < 4 * h; i++)	// a few periods of silence
	begin
		@(negedge clk50mhz);
		assert (wave_out == 4'h0) else report_error("wave_out active while disabled");
	end
	apply_inputs(n, FX_NONE, 0, 0, 1'b1);
	wait_toggle();
	assert (wave_out == 4'hF) else report_error("first level after enable is not high");
	check_run(h, "first high after enable");
endtask

// slide over 13 notes in octaves 4 and 5
// every run there is shorter than 12 slide steps so some toggle lands on a note in between
task automatic test_porta();
	int r;
	int up;
	int a;
	int b;
	int s;
	int len;
	int hit;
	int last;
	int budget;
	int elapsed;
	logic found;
	logic seen_mid;
	take_bits(1, r);
	take_bits(1, up);
	a = (up != 0) ? 48 + r : 63 - r;
	b = (up != 0) ? a + 13 : a - 13;
	take_bits(2, s);
	apply_inputs(a, FX_PORTA, s, 0, 1'b1);
	wait_toggle();
	measure_run(len);
	check_run(half_of(a), "porta start");
	apply_inputs(b, FX_PORTA, s, 0, 1'b1);
	// whole slide plus the wait for the first tick and one more period
	budget   = ((b > a) ? b - a : a - b) * (s + 1) * TICK_GAP + TICK_GAP;
	budget   = budget + ((half_of(a) > half_of(b)) ? half_of(a) : half_of(b));
	last     = a;
	elapsed  = 0;
	seen_mid = 1'b0;
	wait_toggle();
	while (elapsed <= budget)
	begin
		measure_run(len);
		elapsed = elapsed + len;
		found   = 1'b0;
		hit     = last;
		for (int m = ((a < b) ? a : b); m <= ((a < b) ? b : a); m++)
		begin
			if (half_of(m) == len)
			begin
				found = 1'b1;
				hit   = m;
			end
		end
		assert (found) else report_error($sformatf("porta run %0d fits no note", len));
		assert ((b > a) ? (hit >= last) : (hit <= last))
			else report_error($sformatf("porta went from note %0d back to %0d", last, hit));
		if (hit != a && hit != b)
			seen_mid = 1'b1;
		last = hit;
	end
	assert (seen_mid)
		else report_error($sformatf("porta jumped from note %0d to %0d with no note between",
			a, b));
	check_run(half_of(b), "porta end");
	check_run(half_of(b), "porta end");
endtask

// with porta off the note jumps straight to the new value
task automatic test_porta_off();
	int a;
	int b;
	int s;
	int len;
	take_bits(6, a);
	take_bits(6, b);
	if (b == a)
		b = (a + 7) % 64;
	take_bits(2, s);
	apply_inputs(a, FX_NONE, s, 0, 1'b1);
	wait_toggle();
	measure_run(len);
	check_run(half_of(a), "porta off, old note");
	apply_inputs(b, FX_NONE, s, 0, 1'b1);
	wait_toggle();
	measure_run(len);	// old or new note but never one in between
	assert (len == half_of(a) || len == half_of(b))
		else report_error($sformatf("porta off run %0d is an intermediate note", len));
	check_run(half_of(b), "porta off, new note");
endtask

task automatic test_vibrato();
	int n;
	int d;
	int h;
	int st;
	int pk;
	int len;
	int elapsed;
	logic found;
	logic seen_long;
	logic seen_short;
	logic seen_pk;
	take_bits(2, n);
	n  = 60 + n;	// top notes give the shortest runs
	take_bits(2, d);
	h  = half_of(n);
	st = h >> 5;
	pk = 2 * d + 1;
	apply_inputs(n, FX_VIBRATO, 3, d, 1'b1);	// slowest steps
	seen_long  = 1'b0;
	seen_short = 1'b0;
	seen_pk    = 1'b0;
	elapsed    = 0;
	wait_toggle();
	while (!(seen_long && seen_short && seen_pk))
	begin
		measure_run(len);
		elapsed = elapsed + len;
		found   = 1'b0;
		for (int m = 0; m <= pk; m++)
		begin
			if (len == h + m * st || len == h - m * st)
			begin
				found = 1'b1;
				seen_long  = seen_long | (m > 0 && len > h);
				seen_short = seen_short | (m > 0 && len < h);
				seen_pk    = seen_pk | (m == pk);
			end
		end
		assert (found) else report_error($sformatf("vibrato run %0d off the grid", len));
		if (elapsed > 80000)
			report_timeout("vibrato never showed both signs and its peak");
	end
	apply_inputs(n, FX_NONE, 0, 0, 1'b1);
	wait_toggle();
	measure_run(len);
	check_run(h, "after vibrato");
	check_run(h, "after vibrato");
endtask

`endif

//--- tb_sq_channel.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sq_channel;

	import note_pkg::*;
	import fx_pkg::*;

	localparam int SHIFT     = 8;	// short periods for simulation
	localparam int TICK_GAP  = 16;	// cycles between note_clk pulses
	localparam int RUN_LIMIT = 20000;	// longer than any half period at this shift

	logic        clk50mhz = 1'b0;
	logic        rst_n;
	note_t       note_in;
	logic        note_clk;
	logic        channel_en;
	fx_ctrl_t    fx;
	logic [3:0]  wave_out;
	logic [31:0] lfsr_state;	// random source for notes and options

	sq_channel #(
		.PERIOD_SHIFT (SHIFT)
	) uut (
		.clk50mhz   (clk50mhz),
		.rst_n      (rst_n),
		.note_in    (note_in),
		.note_clk   (note_clk),
		.channel_en (channel_en),
		.fx         (fx),
		.wave_out   (wave_out)
	);

	always #10 clk50mhz = ~clk50mhz;	// 20 ns period

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// n fresh bits, one lfsr step per bit
	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
	endtask

	// expected half period: table entry, octave shift, then global shift
	function automatic int half_of(input int n);
		int h;
		h = int'(semitone_period(4'(n % 12)));
		h = h >> (n / 12);
		return h >> SHIFT;
	endfunction

	task automatic stop_fail();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic report_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		stop_fail();
	endtask

	task automatic report_timeout(input string msg);
		$display("timeout: %s", msg);
		stop_fail();
	endtask

	// inputs move 2 ns after the rising edge
	task automatic apply_inputs(input int n, input fx_sel_e sel, input int oa,
		input int ob, input logic en);
		@(posedge clk50mhz);
		#2;
		note_in    = 6'(n);
		fx.sel     = sel;
		fx.opt_a   = 2'(oa);
		fx.opt_b   = 2'(ob);
		channel_en = en;
	endtask

	// free running tick, one cycle high out of TICK_GAP
	task automatic tick_gen();
		note_clk = 1'b0;
		forever
		begin
			@(posedge clk50mhz);
			#2 note_clk = 1'b1;
			@(posedge clk50mhz);
			#2 note_clk = 1'b0;
			repeat (TICK_GAP - 2) @(posedge clk50mhz);
		end
	endtask

	`include "tb_sq_tasks.svh"

	initial
	begin
		tick_gen();
	end

	initial
	begin
		lfsr_state = 32'h71aa;
		rst_n      = 1'b0;
		note_in    = '0;
		channel_en = 1'b0;
		fx         = '0;
		repeat (3) @(posedge clk50mhz);	// 3 cycles in reset
		#2 rst_n = 1'b1;
		test_plain();
		test_enable();
		test_porta();
		test_porta_off();
		test_vibrato();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
